//--- rtl/mem_settings.svh
// sizes shared by rtl and bench; line bytes and line count must stay powers of two
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// address and data word width
`define MEM_XLEN 32

// bytes per cache line, also the off-chip bus width in bytes
`define MEM_LINE_BYTES 16

// lines per cache
`define MEM_CACHE_LINES 16

`endif

//--- rtl/mem_pkg.sv
// field widths follow mem_settings.svh; the tag takes every address bit above index and offset
`default_nettype none
`include "mem_settings.svh"

package mem_pkg;

    localparam int MEM_OFFSET_W = $clog2(`MEM_LINE_BYTES);  // word select plus byte lane
    localparam int MEM_INDEX_W  = $clog2(`MEM_CACHE_LINES);
    localparam int MEM_TAG_W    = `MEM_XLEN - MEM_INDEX_W - MEM_OFFSET_W;

    typedef struct packed {
        logic [MEM_TAG_W-1:0]    tag;
        logic [MEM_INDEX_W-1:0]  index;
        logic [MEM_OFFSET_W-1:0] offset;
    } mem_addr_s;

    // one address word, seen raw or split into cache fields
    typedef union packed {
        logic [`MEM_XLEN-1:0] raw;
        mem_addr_s            f;
    } mem_addr_u;

    typedef enum logic [1:0] {SIZE_WORD = 2'd0, SIZE_BYTE = 2'd1, SIZE_HALF = 2'd2} access_size_e;

    typedef enum logic [1:0] {OWNER_NONE = 2'd0, OWNER_INST = 2'd1, OWNER_DATA = 2'd2} refill_owner_e;

endpackage

`default_nettype wire

//--- rtl/line_cache.sv
// direct-mapped write-back cache; addr must stay steady through a refill, byte and half reads zero-extend
`timescale 1ns/1ns
`default_nettype none
`include "mem_settings.svh"

module line_cache import mem_pkg::*; (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [`MEM_XLEN-1:0]           addr,
    input  logic [`MEM_XLEN-1:0]           data_in,
    input  logic                           write_enable,
    input  logic                           read_enable,
    input  access_size_e                   byte_size,
    input  logic                           load_enable,     // from refill arbiter
    input  logic [`MEM_LINE_BYTES*8-1:0]   write_load_data, // filled line
    input  logic                           save_ready,      // victim already written back
    output logic                           data_hit,
    output logic                           status_ready,
    output logic                           miss_req,
    output logic                           victim_dirty,
    output logic                           load_complete,
    output logic [`MEM_XLEN-1:0]           data_out,
    output logic [`MEM_XLEN-1:0]           victim_addr,
    output logic [`MEM_LINE_BYTES*8-1:0]   write_back_data
);

    localparam int WORD_BYTES = `MEM_XLEN / 8;
    localparam int LANE_W     = $clog2(WORD_BYTES);
    localparam int WSEL_W     = MEM_OFFSET_W - LANE_W;
    localparam int LINE_W     = `MEM_LINE_BYTES * 8;

    logic [MEM_TAG_W-1:0] tag_arr  [`MEM_CACHE_LINES];
    logic [LINE_W-1:0]    line_arr [`MEM_CACHE_LINES];
    logic [`MEM_CACHE_LINES-1:0] valid_arr;
    logic [`MEM_CACHE_LINES-1:0] dirty_arr;

    mem_addr_u               req;
    mem_addr_u               vic;
    logic [MEM_INDEX_W-1:0]  idx;
    logic [WSEL_W-1:0]       word_sel;
    logic [LANE_W-1:0]       lane;

    logic [LINE_W-1:0]       cur_line;
    logic [`MEM_XLEN-1:0]    cur_word;
    logic [`MEM_XLEN-1:0]    shifted;
    logic [WORD_BYTES-1:0]   lane_mask;
    logic [`MEM_XLEN-1:0]    wdata_rep;
    logic [`MEM_XLEN-1:0]    merged_word;
    logic [LINE_W-1:0]       merged_line;

    logic                    write_hit;
    logic                    load_commit;

    assign req.raw  = addr;
    assign idx      = req.f.index;
    assign word_sel = req.f.offset[MEM_OFFSET_W-1:LANE_W];
    assign lane     = req.f.offset[LANE_W-1:0];

    assign cur_line = line_arr[idx];
    assign cur_word = cur_line[word_sel*`MEM_XLEN +: `MEM_XLEN];

    assign data_hit     = valid_arr[idx] && (tag_arr[idx] == req.f.tag);
    assign status_ready = !load_enable;                 // busy only while the line is replaced
    assign miss_req     = (read_enable || write_enable) && status_ready && !data_hit;

    // victim is whatever currently sits at the requested index
    assign victim_dirty    = valid_arr[idx] && dirty_arr[idx];
    assign write_back_data = cur_line;

    always_comb begin
        vic.f.tag    = tag_arr[idx];
        vic.f.index  = idx;
        vic.f.offset = '0;
    end
    assign victim_addr = vic.raw;

    // a dirty victim holds off the load until the writeback is done
    assign load_commit   = load_enable && (!victim_dirty || save_ready);
    assign load_complete = load_commit;
    assign write_hit     = write_enable && status_ready && data_hit;

    // read path, selected lanes moved down to bit 0
    always_comb begin
        shifted = cur_word >> {lane, 3'b000};
        case (byte_size)
            SIZE_BYTE: data_out = {{(`MEM_XLEN-8){1'b0}}, shifted[7:0]};
            SIZE_HALF: data_out = {{(`MEM_XLEN-16){1'b0}}, shifted[15:0]};
            default:   data_out = cur_word;
        endcase
    end

    // store path, replicate data then keep only the enabled lanes
    always_comb begin
        case (byte_size)
            SIZE_BYTE: begin
                lane_mask = WORD_BYTES'(1) << lane;
                wdata_rep = {WORD_BYTES{data_in[7:0]}};
            end
            SIZE_HALF: begin
                lane_mask = WORD_BYTES'(3) << lane;
                wdata_rep = {(WORD_BYTES/2){data_in[15:0]}};
            end
            default: begin
                lane_mask = '1;
                wdata_rep = data_in;
            end
        endcase
        merged_word = cur_word;
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (lane_mask[b]) begin
                merged_word[b*8 +: 8] = wdata_rep[b*8 +: 8];
            end
        end
        merged_line = cur_line;
        merged_line[word_sel*`MEM_XLEN +: `MEM_XLEN] = merged_word;
    end

    always_ff @(posedge clk) begin
        if (load_commit) begin
            line_arr[idx] <= write_load_data;
            tag_arr[idx]  <= req.f.tag;
        end else if (write_hit) begin
            line_arr[idx] <= merged_line;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_arr <= '0;
            dirty_arr <= '0;
        end else if (load_commit) begin
            valid_arr[idx] <= 1'b1;
            dirty_arr[idx] <= 1'b0;   // fresh line matches memory
        end else if (write_hit) begin
            dirty_arr[idx] <= 1'b1;
        end
    end

    // top gating must keep stores away from a line being replaced
    a_no_write_during_load: assert property (
        @(posedge clk) disable iff (!rst_n) !(write_enable && load_enable)
    ) else $error("line_cache: write_enable high during load_enable");

    a_size_legal: assert property (
        @(posedge clk) disable iff (!rst_n) (read_enable || write_enable) |-> byte_size != 2'd3
    ) else $error("line_cache: illegal byte_size %0d", byte_size);

    a_half_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        (read_enable || write_enable) && byte_size == SIZE_HALF |-> !addr[0]
    ) else $error("line_cache: odd halfword address %h", addr);

endmodule

`default_nettype wire

//--- rtl/refill_arbiter.sv
// one refill at a time, instruction side wins in idle; offchip_mem_ready is a one-cycle pulse
`timescale 1ns/1ns
`default_nettype none
`include "mem_settings.svh"

module refill_arbiter import mem_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  inst_miss,
    input  logic [`MEM_XLEN-1:0]  inst_addr,
    input  logic                  inst_load_complete,
    input  logic                  data_miss,
    input  logic [`MEM_XLEN-1:0]  data_addr,
    input  logic                  data_victim_dirty,
    input  logic [`MEM_XLEN-1:0]  data_victim_addr,
    input  logic                  data_load_complete,
    input  logic                  offchip_mem_ready,
    output logic                  inst_load_en,
    output logic                  data_load_en,
    output logic                  data_save_ready,
    output logic                  offchip_mem_read_en,
    output logic                  offchip_mem_write_en,
    output logic [`MEM_XLEN-1:0]  offchip_mem_addr
);

    localparam logic [2:0] ST_IDLE      = 3'd0;
    localparam logic [2:0] ST_READ      = 3'd1;
    localparam logic [2:0] ST_WRITEBACK = 3'd2;
    localparam logic [2:0] ST_LOAD      = 3'd3;
    localparam logic [2:0] ST_WAIT_IDLE = 3'd4;

    logic [2:0]           state;
    refill_owner_e        owner;
    logic [`MEM_XLEN-1:0] line_addr;   // aligned address of the line being fetched

    mem_addr_u            inst_line;
    mem_addr_u            data_line;
    logic                 owner_miss;
    logic                 owner_load_complete;

    // clear the offset field to line-align each requester
    always_comb begin
        inst_line.raw      = inst_addr;
        inst_line.f.offset = '0;
        data_line.raw      = data_addr;
        data_line.f.offset = '0;
    end

    assign owner_miss          = (owner == OWNER_INST) ? inst_miss : data_miss;
    assign owner_load_complete = (owner == OWNER_INST) ? inst_load_complete : data_load_complete;

    // victim address only goes out while writing back
    assign offchip_mem_addr = (state == ST_WRITEBACK) ? data_victim_addr : line_addr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state                <= ST_IDLE;
            owner                <= OWNER_NONE;
            line_addr            <= '0;
            offchip_mem_read_en  <= 1'b0;
            offchip_mem_write_en <= 1'b0;
            inst_load_en         <= 1'b0;
            data_load_en         <= 1'b0;
            data_save_ready      <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (inst_miss) begin              // fixed priority
                        owner               <= OWNER_INST;
                        line_addr           <= inst_line.raw;
                        offchip_mem_read_en <= 1'b1;
                        state               <= ST_READ;
                    end else if (data_miss) begin
                        owner               <= OWNER_DATA;
                        line_addr           <= data_line.raw;
                        offchip_mem_read_en <= 1'b1;
                        state               <= ST_READ;
                    end
                end
                ST_READ: begin
                    if (offchip_mem_ready) begin
                        offchip_mem_read_en <= 1'b0;
                        if (owner == OWNER_DATA && data_victim_dirty) begin
                            offchip_mem_write_en <= 1'b1;
                            state                <= ST_WRITEBACK;
                        end else begin
                            if (owner == OWNER_INST) begin
                                inst_load_en <= 1'b1;
                            end else begin
                                data_load_en <= 1'b1;
                            end
                            state <= ST_LOAD;
                        end
                    end
                end
                ST_WRITEBACK: begin
                    if (offchip_mem_ready) begin
                        offchip_mem_write_en <= 1'b0;
                        data_save_ready      <= 1'b1;  // lets the cache overwrite the victim
                        data_load_en         <= 1'b1;
                        state                <= ST_LOAD;
                    end
                end
                ST_LOAD: begin
                    if (owner_load_complete) begin
                        inst_load_en    <= 1'b0;
                        data_load_en    <= 1'b0;
                        data_save_ready <= 1'b0;
                        state           <= ST_WAIT_IDLE;
                    end
                end
                ST_WAIT_IDLE: begin
                    // requester takes its hit, then its miss drops
                    if (!owner_miss) begin
                        owner <= OWNER_NONE;
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    a_one_enable: assert property (
        @(posedge clk) disable iff (!rst_n) !(offchip_mem_read_en && offchip_mem_write_en)
    ) else $error("refill_arbiter: read and write enables both high");

    a_addr_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (offchip_mem_read_en || offchip_mem_write_en) && !offchip_mem_ready
        |=> $stable(offchip_mem_addr)
    ) else $error("refill_arbiter: offchip_mem_addr moved before ready");

endmodule

`default_nettype wire

//--- rtl/mem_controller.sv
// two direct-mapped caches on one line bus; no coherence between them, aligned accesses only
`timescale 1ns/1ns
`default_nettype none
`include "mem_settings.svh"

module mem_controller import mem_pkg::*; (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [`MEM_XLEN-1:0]           inst_mem_addr,
    input  logic                           inst_read_en,
    output logic [`MEM_XLEN-1:0]           inst_mem_rdata,
    output logic                           inst_mem_ready,
    input  logic [`MEM_XLEN-1:0]           mem_addr,
    input  logic                           read_en,
    input  logic                           write_en,
    input  access_size_e                   byte_size,
    input  logic [`MEM_XLEN-1:0]           mem_wdata,
    output logic [`MEM_XLEN-1:0]           mem_rdata,
    output logic                           mem_ready,
    input  logic [`MEM_LINE_BYTES*8-1:0]   offchip_mem_data,
    input  logic                           offchip_mem_ready,
    output logic [`MEM_LINE_BYTES*8-1:0]   offchip_mem_wdata,
    output logic                           offchip_mem_write_en,
    output logic                           offchip_mem_read_en,
    output logic [`MEM_XLEN-1:0]           offchip_mem_addr
);

    logic inst_load_en, inst_rd_gated, inst_hit, inst_status, inst_miss, inst_load_complete;
    logic data_load_en, data_rd_gated, data_wr_gated, data_hit, data_status, data_miss;
    logic data_victim_dirty, data_load_complete, data_save_ready;
    logic [`MEM_XLEN-1:0]         data_victim_addr;
    logic [`MEM_LINE_BYTES*8-1:0] fill_line;

    // back-pressure while a line is being written in
    assign inst_rd_gated = inst_read_en && !inst_load_en;
    assign data_rd_gated = read_en && !data_load_en;
    assign data_wr_gated = write_en && !data_load_en;

    assign inst_mem_ready = inst_rd_gated && inst_status && inst_hit;
    assign mem_ready      = (data_rd_gated || data_wr_gated) && data_status && data_hit;

    // read data is only on the bus for the ready cycle, a dirty writeback may come first
    always_ff @(posedge clk) begin
        if (offchip_mem_read_en && offchip_mem_ready) begin
            fill_line <= offchip_mem_data;
        end
    end

    line_cache u_icache (
        .clk             (clk),
        .rst_n           (rst_n),
        .addr            (inst_mem_addr),
        .data_in         ('0),
        .write_enable    (1'b0),           // read-only, words only
        .read_enable     (inst_rd_gated),
        .byte_size       (SIZE_WORD),
        .load_enable     (inst_load_en),
        .write_load_data (fill_line),
        .save_ready      (1'b1),           // never dirty
        .data_hit        (inst_hit),
        .status_ready    (inst_status),
        .miss_req        (inst_miss),
        .victim_dirty    (),
        .load_complete   (inst_load_complete),
        .data_out        (inst_mem_rdata),
        .victim_addr     (),
        .write_back_data ()
    );

    line_cache u_dcache (
        .clk             (clk),
        .rst_n           (rst_n),
        .addr            (mem_addr),
        .data_in         (mem_wdata),
        .write_enable    (data_wr_gated),
        .read_enable     (data_rd_gated),
        .byte_size       (byte_size),
        .load_enable     (data_load_en),
        .write_load_data (fill_line),
        .save_ready      (data_save_ready),
        .data_hit        (data_hit),
        .status_ready    (data_status),
        .miss_req        (data_miss),
        .victim_dirty    (data_victim_dirty),
        .load_complete   (data_load_complete),
        .data_out        (mem_rdata),
        .victim_addr     (data_victim_addr),
        .write_back_data (offchip_mem_wdata)
    );

    refill_arbiter u_refill (
        .clk                  (clk),
        .rst_n                (rst_n),
        .inst_miss            (inst_miss),
        .inst_addr            (inst_mem_addr),
        .inst_load_complete   (inst_load_complete),
        .data_miss            (data_miss),
        .data_addr            (mem_addr),
        .data_victim_dirty    (data_victim_dirty),
        .data_victim_addr     (data_victim_addr),
        .data_load_complete   (data_load_complete),
        .offchip_mem_ready    (offchip_mem_ready),
        .inst_load_en         (inst_load_en),
        .data_load_en         (data_load_en),
        .data_save_ready      (data_save_ready),
        .offchip_mem_read_en  (offchip_mem_read_en),
        .offchip_mem_write_en (offchip_mem_write_en),
        .offchip_mem_addr     (offchip_mem_addr)
    );

endmodule

`default_nettype wire

//--- bench/offchip_mem_model.sv
// line-wide memory, unwritten lines read as address xor a5a5a5a5 per word; latency 1 to 4 cycles
`timescale 1ns/1ns
`default_nettype none
`include "mem_settings.svh"

module offchip_mem_model (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [`MEM_XLEN-1:0]          addr,
    input  logic                          read_en,
    input  logic                          write_en,
    input  logic [`MEM_LINE_BYTES*8-1:0]  wdata,
    output logic [`MEM_LINE_BYTES*8-1:0]  rdata,
    output logic                          ready,
    output int unsigned                   wr_count,
    output logic [`MEM_XLEN-1:0]          last_wr_addr,
    output logic [`MEM_LINE_BYTES*8-1:0]  last_wr_data
);

    logic [`MEM_LINE_BYTES*8-1:0] mem [logic [`MEM_XLEN-1:0]];
    logic [31:0] lat_seed = 32'h2f5a;
    int unsigned count;
    int unsigned lat;

    function logic [31:0] lcg_next();
        lat_seed = lat_seed * 32'd1664525 + 32'd1013904223;
        return lat_seed;
    endfunction

    // power-on contents of a line never written
    function automatic logic [`MEM_LINE_BYTES*8-1:0] init_line(input logic [31:0] a);
        logic [`MEM_LINE_BYTES*8-1:0] l;
        for (int w = 0; w < `MEM_LINE_BYTES / 4; w++) begin
            l[w*32 +: 32] = (a + 32'(4 * w)) ^ 32'ha5a5a5a5;
        end
        return l;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready        <= 1'b0;
            rdata        <= '0;
            count        <= 0;
            lat          <= 1;
            wr_count     <= 0;
            last_wr_addr <= '0;
            last_wr_data <= '0;
        end else if (ready) begin
            ready <= 1'b0;   // one-cycle pulse, enable drops on this edge
            count <= 0;
        end else if (read_en || write_en) begin
            if (count + 1 >= lat) begin
                ready <= 1'b1;
                lat   <= 1 + lcg_next() % 4;
                if (read_en) begin
                    rdata <= mem.exists(addr) ? mem[addr] : init_line(addr);
                end else begin
                    mem[addr] = wdata;
                    wr_count     <= wr_count + 1;   // captured for the eviction check
                    last_wr_addr <= addr;
                    last_wr_data <= wdata;
                end
            end else begin
                count <= count + 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/tb_mem_controller.sv
// data traffic kept in 0x1000-0x1fff and fetches in 0x0000-0x0fff, the caches are not coherent
`timescale 1ns/1ns
`default_nettype none
`include "mem_settings.svh"

module tb_mem_controller import mem_pkg::*; ();

    logic clk, rst_n;
    logic [31:0] inst_mem_addr, inst_mem_rdata, mem_addr, mem_wdata, mem_rdata, offchip_mem_addr;
    logic inst_read_en, inst_mem_ready, read_en, write_en, mem_ready;
    logic offchip_mem_read_en, offchip_mem_write_en, offchip_mem_ready;
    access_size_e byte_size;
    logic [127:0] offchip_mem_data, offchip_mem_wdata, last_wr_data;
    logic [31:0] last_wr_addr, inst_exp, data_exp;
    int unsigned wr_count;
    logic [31:0] seed = 32'h2f5a;
    logic [7:0] shadow [logic [31:0]];   // bytes written so far

    mem_controller u_dut (.*);

    offchip_mem_model u_mem (
        .clk(clk), .rst_n(rst_n), .addr(offchip_mem_addr), .read_en(offchip_mem_read_en),
        .write_en(offchip_mem_write_en), .wdata(offchip_mem_wdata), .rdata(offchip_mem_data),
        .ready(offchip_mem_ready), .wr_count(wr_count), .last_wr_addr(last_wr_addr),
        .last_wr_data(last_wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function logic [31:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    function automatic logic [7:0] shadow_byte(input logic [31:0] a);
        logic [31:0] w;
        if (shadow.exists(a)) return shadow[a];
        w = {a[31:2], 2'b00} ^ 32'ha5a5a5a5;
        return w[a[1:0]*8 +: 8];
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] a);
        return {shadow_byte(a + 3), shadow_byte(a + 2), shadow_byte(a + 1), shadow_byte(a)};
    endfunction

    function automatic logic [127:0] shadow_line(input logic [31:0] a);
        logic [127:0] l;
        for (int w = 0; w < 4; w++) l[w*32 +: 32] = shadow_word(a + 32'(4 * w));
        return l;
    endfunction

    task automatic store_shadow(input access_size_e sz, input logic [31:0] a,
                                input logic [31:0] wd);
        int n;
        n = (sz == SIZE_BYTE) ? 1 : (sz == SIZE_HALF) ? 2 : 4;   // only enabled lanes change
        for (int b = 0; b < n; b++) shadow[a + 32'(b)] = wd[b*8 +: 8];
    endtask

    task abort_run();
        $display("test failed");
        $fatal(1);
    endtask

    task report_err(input string name, input logic [127:0] got, input logic [127:0] exp);
        $display("ERR %s got %h expected %h", name, got, exp);
        abort_run();
    endtask

    task timeout_fail(input string what);
        $display("timed out waiting for %s", what);
        abort_run();
    endtask

    task automatic fetch_word(input logic [31:0] a);
        int n;
        @(posedge clk);
        inst_mem_addr <= a;
        inst_read_en  <= 1'b1;
        inst_exp      <= shadow_word(a);
        n = 0;
        @(negedge clk);
        while (!inst_mem_ready) begin
            n++;
            if (n > 100) timeout_fail("instruction port ready");
            @(negedge clk);
        end
        @(posedge clk);
        inst_read_en <= 1'b0;
    endtask

    task automatic data_access(input logic we, input access_size_e sz, input logic [31:0] a,
                               input logic [31:0] wd);
        int n;
        @(posedge clk);
        mem_addr  <= a;
        byte_size <= sz;
        mem_wdata <= wd;
        write_en  <= we;
        read_en   <= !we;
        data_exp  <= shadow_word(a);
        n = 0;
        @(negedge clk);
        while (!mem_ready) begin
            n++;
            if (n > 100) timeout_fail("data port ready");
            @(negedge clk);
        end
        if (we) store_shadow(sz, a, wd);   // commits on the coming edge
        @(posedge clk);
        read_en  <= 1'b0;
        write_en <= 1'b0;
    endtask

    task automatic random_write();
        logic [31:0] r;
        logic [31:0] a;
        access_size_e sz;
        r  = lcg_next();
        a  = 32'h1000 | {20'h0, r[11:0]};
        sz = access_size_e'(r[15:12] % 3);
        if (sz == SIZE_HALF) a[0] = 1'b0;
        if (sz == SIZE_WORD) a[1:0] = 2'b00;
        data_access(1'b1, sz, a, lcg_next());
        data_access(1'b0, SIZE_WORD, {a[31:2], 2'b00}, '0);
    endtask

    // both ports miss on the same edge, instruction line goes out first
    task automatic both_miss();
        int n;
        logic i_done, d_done, i_seen, d_seen;
        @(posedge clk);
        inst_mem_addr <= 32'h0f80;
        inst_read_en  <= 1'b1;
        inst_exp      <= shadow_word(32'h0f80);
        mem_addr      <= 32'h1f80;
        byte_size     <= SIZE_WORD;
        read_en       <= 1'b1;
        data_exp      <= shadow_word(32'h1f80);
        n = 0;
        @(negedge clk);
        while (!offchip_mem_read_en) begin
            n++;
            if (n > 20) timeout_fail("first off-chip read");
            @(negedge clk);
        end
        assert (offchip_mem_addr == 32'h0f80)
            else report_err("offchip_mem_addr", offchip_mem_addr, 32'h0f80);
        i_done = 1'b0;
        d_done = 1'b0;
        n = 0;
        while (!(i_done && d_done)) begin
            @(negedge clk);
            n++;
            if (n > 200) timeout_fail("both ports after a shared miss");
            i_seen = inst_mem_ready;
            d_seen = mem_ready;
            @(posedge clk);
            if (i_seen) begin
                inst_read_en <= 1'b0;
                i_done = 1'b1;
            end
            if (d_seen) begin
                read_en <= 1'b0;
                d_done = 1'b1;
            end
        end
    endtask

    a_reset_quiet: assert property (@(posedge clk) (!rst_n || $rose(rst_n)) |->
        !(offchip_mem_read_en || offchip_mem_write_en || inst_mem_ready || mem_ready))
        else report_err("reset controls", {offchip_mem_read_en, offchip_mem_write_en,
                                           inst_mem_ready, mem_ready}, '0);
    a_one_enable: assert property (@(posedge clk) !(offchip_mem_read_en && offchip_mem_write_en))
        else report_err("offchip enables", {offchip_mem_read_en, offchip_mem_write_en}, '0);
    a_line_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        (offchip_mem_read_en || offchip_mem_write_en) |-> offchip_mem_addr[3:0] == 4'h0)
        else report_err("offchip_mem_addr", $sampled(offchip_mem_addr), '0);
    a_inst_data: assert property (@(posedge clk) disable iff (!rst_n)
        inst_read_en && inst_mem_ready |-> inst_mem_rdata == inst_exp)
        else report_err("inst_mem_rdata", $sampled(inst_mem_rdata), $sampled(inst_exp));
    a_data_read: assert property (@(posedge clk) disable iff (!rst_n)
        read_en && mem_ready && byte_size == SIZE_WORD |-> mem_rdata == data_exp)
        else report_err("mem_rdata", $sampled(mem_rdata), $sampled(data_exp));
    a_writeback: assert property (@(posedge clk) disable iff (!rst_n)
        offchip_mem_write_en && offchip_mem_ready |->
        offchip_mem_wdata == shadow_line(offchip_mem_addr))
        else report_err("offchip_mem_wdata", $sampled(offchip_mem_wdata),
                        shadow_line($sampled(offchip_mem_addr)));

    initial begin
        logic [31:0] r;
        int unsigned wr_before;
        rst_n = 1'b0;
        inst_read_en = 1'b0;
        inst_mem_addr = '0;
        read_en = 1'b0;
        write_en = 1'b0;
        mem_addr = '0;
        mem_wdata = '0;
        byte_size = SIZE_WORD;
        inst_exp = '0;
        data_exp = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        both_miss();
        for (int i = 0; i < 8; i++) begin
            r = lcg_next() & 32'h0ffc;
            fetch_word(r);   // miss
            fetch_word(r);   // hit
        end
        for (int i = 0; i < 20; i++) random_write();
        // dirty eviction on index 0
        data_access(1'b1, SIZE_WORD, 32'h1204, 32'hc0ffee11);
        wr_before = wr_count;
        data_access(1'b0, SIZE_WORD, 32'h1304, '0);
        assert (wr_count == wr_before + 1)
            else report_err("wr_count", wr_count, wr_before + 1);
        assert (last_wr_addr == 32'h1200) else report_err("last_wr_addr", last_wr_addr, 32'h1200);
        assert (last_wr_data == shadow_line(32'h1200))
            else report_err("last_wr_data", last_wr_data, shadow_line(32'h1200));
        data_access(1'b0, SIZE_WORD, 32'h1204, '0);
        for (int i = 0; i < 200; i++) begin
            r = lcg_next();
            case (r[9:8])
                2'd0: fetch_word(r & 32'h0ffc);
                2'd1: random_write();
                default: data_access(1'b0, SIZE_WORD, 32'h1000 | (r & 32'h0ffc), '0);
            endcase
        end
        @(posedge clk);
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+rtl
rtl/mem_pkg.sv
rtl/line_cache.sv
rtl/refill_arbiter.sv
rtl/mem_controller.sv
bench/offchip_mem_model.sv
bench/tb_mem_controller.sv

//--- Bender.yml
package:
  name: mem_controller

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mem_pkg.sv
      - rtl/line_cache.sv
      - rtl/refill_arbiter.sv
      - rtl/mem_controller.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/offchip_mem_model.sv
      - bench/tb_mem_controller.sv
